//--- source/cp0Pkg.sv
//------------------------------------------------------------
// CP0 register map
// Register numbers, data width and the Status/Cause field
// positions shared by the register blocks and the read port
//------------------------------------------------------------
`default_nettype none

package cp0Pkg;

    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;

    // Coprocessor register numbers
    localparam logic [RegAddrWidth-1:0] RegBadVAddr = 5'd8;
    localparam logic [RegAddrWidth-1:0] RegCount    = 5'd9;
    localparam logic [RegAddrWidth-1:0] RegCompare  = 5'd11;
    localparam logic [RegAddrWidth-1:0] RegStatus   = 5'd12;
    localparam logic [RegAddrWidth-1:0] RegCause    = 5'd13;
    localparam logic [RegAddrWidth-1:0] RegEpc      = 5'd14;

    // External interrupt lines, IP7..IP2
    localparam int HwIntCount   = 6;
    localparam int TimerIntLine = 5;   // Shared with IP7

    // Status fields
    localparam int StatusImLsb  = 8;
    localparam int StatusBevBit = 22;  // Always reads 1

    // Cause fields
    localparam int CauseIpLsb   = 8;
    localparam int CauseExcLsb  = 2;
    localparam int CauseTiBit   = 30;
    localparam int CauseBdBit   = 31;

endpackage

`default_nettype wire

//--- source/excPkg.sv
//------------------------------------------------------------
// Exception definitions
// Exception kinds in priority order, the raw flag vector
// layout and the MIPS Cause.ExcCode values
//------------------------------------------------------------
`default_nettype none

package excPkg;

    // Listed highest priority first
    typedef enum logic [3:0] {
        ExcNone,
        ExcInterrupt,
        ExcFetchAddr,
        ExcReservedInstr,
        ExcSyscall,
        ExcBreak,
        ExcEret,
        ExcTrap,
        ExcOverflow,
        ExcStoreAddr,
        ExcLoadAddr
    } excKindT;

    // Flag bit n is the n-th kind after ExcNone
    localparam int ExcFlagCount = 10;

    localparam int ExcCodeWidth = 5;

    localparam logic [ExcCodeWidth-1:0] CodeInt  = 5'd0;
    localparam logic [ExcCodeWidth-1:0] CodeAdel = 5'd4;   // Fetch and load address error
    localparam logic [ExcCodeWidth-1:0] CodeAdes = 5'd5;
    localparam logic [ExcCodeWidth-1:0] CodeSys  = 5'd8;
    localparam logic [ExcCodeWidth-1:0] CodeBp   = 5'd9;
    localparam logic [ExcCodeWidth-1:0] CodeRi   = 5'd10;
    localparam logic [ExcCodeWidth-1:0] CodeOv   = 5'd12;
    localparam logic [ExcCodeWidth-1:0] CodeTr   = 5'd13;

endpackage

`default_nettype wire

//--- source/excPriority.sv
//------------------------------------------------------------
// Exception priority encoder
// Picks the highest-priority raised exception flag and
// maps it to its Cause.ExcCode value
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module excPriority
    import excPkg::*;
(
    input  wire logic [ExcFlagCount-1:0] excFlags,
    output excKindT                      excKind,
    output logic      [ExcCodeWidth-1:0] excCode
);

    // Lowest set bit wins, scanning down so it lands last
    always_comb begin
        excKind = ExcNone;
        for (int i = ExcFlagCount - 1; i >= 0; i--) begin
            if (excFlags[i]) begin
                excKind = excKindT'(i + 1);
            end
        end
    end

    always_comb begin
        excCode = '0;
        case (excKind)
            ExcInterrupt:     excCode = CodeInt;
            ExcFetchAddr:     excCode = CodeAdel;
            ExcReservedInstr: excCode = CodeRi;
            ExcSyscall:       excCode = CodeSys;
            ExcBreak:         excCode = CodeBp;
            ExcTrap:          excCode = CodeTr;
            ExcOverflow:      excCode = CodeOv;
            ExcStoreAddr:     excCode = CodeAdes;
            ExcLoadAddr:      excCode = CodeAdel;
            default:          excCode = '0;   // ExcNone and Eret carry no code
        endcase
    end

endmodule

`default_nettype wire

//--- source/cp0Timer.sv
//------------------------------------------------------------
// CP0 timer
// Count with its clock divider, Compare, the equality match
// that raises the timer interrupt and the sticky Cause.TI bit
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cp0Timer
    import cp0Pkg::*;
#(
    parameter int CountDivide = 2
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    wrEn,
    input  wire logic [RegAddrWidth-1:0] wrAddr,
    input  wire logic [DataWidth-1:0]    wrData,
    output logic      [DataWidth-1:0]    count,
    output logic      [DataWidth-1:0]    compare,
    output logic                         timerInt,
    output logic                         causeTi
);

    localparam int PhaseWidth = (CountDivide > 1) ? $clog2(CountDivide) : 1;
    localparam logic [PhaseWidth-1:0] PhaseLast = PhaseWidth'(CountDivide - 1);

    logic [PhaseWidth-1:0] phase;
    logic                  wrCount;
    logic                  wrCompare;

    assign wrCount   = wrEn && (wrAddr == RegCount);
    assign wrCompare = wrEn && (wrAddr == RegCompare);

    // Divider phase and Count
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
            count <= '0;
        end else if (wrCount) begin
            phase <= '0;   // Restart the divide period
            count <= wrData;
        end else if (phase == PhaseLast) begin
            phase <= '0;
            count <= count + 1'b1;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= '0;
        end else if (wrCompare) begin
            compare <= wrData;
        end
    end

    assign timerInt = (count == compare);

    // Sticky until software rewrites Compare
    always_ff @(posedge clk) begin
        if (reset) begin
            causeTi <= 1'b0;
        end else if (wrCompare) begin
            causeTi <= 1'b0;
        end else if (timerInt) begin
            causeTi <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/cp0Exception.sv
//------------------------------------------------------------
// CP0 exception state
// Status, Cause, EPC and BadVAddr, updated by software
// writes, exception entry and Eret
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cp0Exception
    import cp0Pkg::*;
    import excPkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    wrEn,
    input  wire logic [RegAddrWidth-1:0] wrAddr,
    input  wire logic [DataWidth-1:0]    wrData,
    input  wire logic [HwIntCount-1:0]   hwInt,
    input  wire logic                    timerInt,
    input  wire excKindT                 excKind,
    input  wire logic [ExcCodeWidth-1:0] excCode,
    input  wire logic [DataWidth-1:0]    excPc,
    input  wire logic [DataWidth-1:0]    excBadAddr,
    input  wire logic                    excInDelaySlot,
    output logic      [7:0]              statusIm,
    output logic                         statusExl,
    output logic                         statusIe,
    output logic      [7:0]              causeIp,
    output logic      [ExcCodeWidth-1:0] causeExc,
    output logic                         causeBd,
    output logic      [DataWidth-1:0]    epc,
    output logic      [DataWidth-1:0]    badVAddr
);

    logic                  excEntry;
    logic                  isEret;
    logic                  wrStatus;
    logic                  wrCause;
    logic                  wrEpc;
    logic [HwIntCount-1:0] hwIntAll;
    logic [HwIntCount-1:0] ipHw;   // IP7..IP2
    logic [1:0]            ipSw;   // IP1..IP0

    assign excEntry = (excKind != ExcNone) && (excKind != ExcEret);
    assign isEret   = (excKind == ExcEret);

    assign wrStatus = wrEn && (wrAddr == RegStatus);
    assign wrCause  = wrEn && (wrAddr == RegCause);
    assign wrEpc    = wrEn && (wrAddr == RegEpc);

    // Timer shares the top hardware line
    always_comb begin
        hwIntAll = hwInt;
        hwIntAll[TimerIntLine] = hwInt[TimerIntLine] | timerInt;
    end

    // Status.IM and Status.IE
    always_ff @(posedge clk) begin
        if (reset) begin
            statusIm <= '0;
            statusIe <= 1'b0;
        end else if (wrStatus) begin
            statusIm <= wrData[StatusImLsb +: 8];
            statusIe <= wrData[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            statusExl <= 1'b0;
        end else if (excEntry) begin
            statusExl <= 1'b1;
        end else if (isEret) begin
            statusExl <= 1'b0;
        end else if (wrStatus) begin
            statusExl <= wrData[1];
        end
    end

    // Cause pending bits
    always_ff @(posedge clk) begin
        if (reset) begin
            ipHw <= '0;
            ipSw <= '0;
        end else begin
            ipHw <= hwIntAll;
            if (wrCause) begin
                ipSw <= wrData[CauseIpLsb +: 2];
            end
        end
    end

    assign causeIp = {ipHw, ipSw};

    always_ff @(posedge clk) begin
        if (reset) begin
            causeExc <= '0;
        end else if (excEntry) begin
            causeExc <= excCode;
        end
    end

    // EPC and BD only captured on the outermost exception
    always_ff @(posedge clk) begin
        if (reset) begin
            epc     <= '0;
            causeBd <= 1'b0;
        end else if (excEntry && !statusExl) begin
            epc     <= excInDelaySlot ? (excPc - 32'd4) : excPc;
            causeBd <= excInDelaySlot;
        end else if (wrEpc && !excEntry) begin
            epc     <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            badVAddr <= '0;
        end else if (excKind == ExcFetchAddr) begin
            badVAddr <= excPc;
        end else if (excKind == ExcLoadAddr || excKind == ExcStoreAddr) begin
            badVAddr <= excBadAddr;
        end
    end

endmodule

`default_nettype wire

//--- source/cp0Regs.sv
//------------------------------------------------------------
// CP0 top level
// Connects the priority encoder, timer and exception state
// and forms the combinational register read port
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cp0Regs
    import cp0Pkg::*;
    import excPkg::*;
#(
    parameter int CountDivide = 2
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    wrEn,
    input  wire logic [RegAddrWidth-1:0] wrAddr,
    input  wire logic [DataWidth-1:0]    wrData,
    input  wire logic [RegAddrWidth-1:0] rdAddr,
    output logic      [DataWidth-1:0]    rdData,
    input  wire logic [HwIntCount-1:0]   hwInt,
    input  wire logic [ExcFlagCount-1:0] excFlags,
    input  wire logic [DataWidth-1:0]    excPc,
    input  wire logic [DataWidth-1:0]    excBadAddr,
    input  wire logic                    excInDelaySlot,
    output logic      [7:0]              statusIm,
    output logic                         statusExl,
    output logic                         statusIe,
    output logic      [7:0]              causeIp,
    output logic      [DataWidth-1:0]    epc
);

    excKindT                  excKind;
    logic [ExcCodeWidth-1:0]  excCode;
    logic [DataWidth-1:0]     count;
    logic [DataWidth-1:0]     compare;
    logic                     timerInt;
    logic                     causeTi;
    logic [ExcCodeWidth-1:0]  causeExc;
    logic                     causeBd;
    logic [DataWidth-1:0]     badVAddr;

    excPriority i_excPriority (
        .excFlags (excFlags),
        .excKind  (excKind),
        .excCode  (excCode)
    );

    cp0Timer #(
        .CountDivide (CountDivide)
    ) i_cp0Timer (
        .clk      (clk),
        .reset    (reset),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData),
        .count    (count),
        .compare  (compare),
        .timerInt (timerInt),
        .causeTi  (causeTi)
    );

    cp0Exception i_cp0Exception (
        .clk            (clk),
        .reset          (reset),
        .wrEn           (wrEn),
        .wrAddr         (wrAddr),
        .wrData         (wrData),
        .hwInt          (hwInt),
        .timerInt       (timerInt),
        .excKind        (excKind),
        .excCode        (excCode),
        .excPc          (excPc),
        .excBadAddr     (excBadAddr),
        .excInDelaySlot (excInDelaySlot),
        .statusIm       (statusIm),
        .statusExl      (statusExl),
        .statusIe       (statusIe),
        .causeIp        (causeIp),
        .causeExc       (causeExc),
        .causeBd        (causeBd),
        .epc            (epc),
        .badVAddr       (badVAddr)
    );

    // Read port, unmapped addresses read zero
    always_comb begin
        rdData = '0;
        case (rdAddr)
            RegBadVAddr: rdData = badVAddr;
            RegCount:    rdData = count;
            RegCompare:  rdData = compare;
            RegStatus: begin
                rdData[StatusImLsb +: 8] = statusIm;
                rdData[StatusBevBit]     = 1'b1;
                rdData[1]                = statusExl;
                rdData[0]                = statusIe;
            end
            RegCause: begin
                rdData[CauseBdBit]                  = causeBd;
                rdData[CauseTiBit]                  = causeTi;
                rdData[CauseIpLsb +: 8]             = causeIp;
                rdData[CauseExcLsb +: ExcCodeWidth] = causeExc;
            end
            RegEpc:      rdData = epc;
            default:     rdData = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- tests/cp0RegsTb.sv
//------------------------------------------------------------
// CP0 testbench
// Replays the command file against the coprocessor and
// checks register reads against the expected values in it
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cp0RegsTb;

    localparam string StimFile    = "tests/cp0Stim.txt";
    localparam int    MaxCommands = 1000;
    localparam int    MaxCycles   = 5000;

    logic        clk;
    logic        reset;
    logic        wrEn;
    logic [4:0]  wrAddr;
    logic [31:0] wrData;
    logic [4:0]  rdAddr;
    logic [31:0] rdData;
    logic [5:0]  hwInt;
    logic [9:0]  excFlags;
    logic [31:0] excPc;
    logic [31:0] excBadAddr;
    logic        excInDelaySlot;
    logic [7:0]  statusIm;
    logic        statusExl;
    logic        statusIe;
    logic [7:0]  causeIp;
    logic [31:0] epc;

    int errors = 0;
    int checks = 0;

    cp0Regs #(
        .CountDivide (2)
    ) i_cp0Regs (
        .clk            (clk),
        .reset          (reset),
        .wrEn           (wrEn),
        .wrAddr         (wrAddr),
        .wrData         (wrData),
        .rdAddr         (rdAddr),
        .rdData         (rdData),
        .hwInt          (hwInt),
        .excFlags       (excFlags),
        .excPc          (excPc),
        .excBadAddr     (excBadAddr),
        .excInDelaySlot (excInDelaySlot),
        .statusIm       (statusIm),
        .statusExl      (statusExl),
        .statusIe       (statusIe),
        .causeIp        (causeIp),
        .epc            (epc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin : watchdog
        int cyc;
        for (cyc = 0; cyc < MaxCycles; cyc++) begin
            @(posedge clk);
        end
        $display("Timeout: simulation still running after %0d cycles", MaxCycles);
        $display("=== FAIL ===");
        $finish;
    end

    // Core-side outputs laid out like the register word
    function automatic logic [31:0] outputWord(input logic [4:0] addr);
        case (addr)
            5'd12:   return {16'h0, statusIm, 6'h0, statusExl, statusIe};
            5'd13:   return {16'h0, causeIp, 8'h0};
            5'd14:   return epc;
            default: return '0;
        endcase
    endfunction

    // Register bits that the core-side outputs carry
    function automatic logic [31:0] outputFields(input logic [4:0] addr);
        case (addr)
            5'd12:   return 32'h0000_ff03;
            5'd13:   return 32'h0000_ff00;
            5'd14:   return 32'hffff_ffff;
            default: return '0;
        endcase
    endfunction

    // One-cycle register write, returns on the next falling edge
    task automatic writeReg(input logic [31:0] addr, input logic [31:0] data);
        wrEn   = 1'b1;
        wrAddr = addr[4:0];
        wrData = data;
        @(posedge clk);
        @(negedge clk);
        wrEn   = 1'b0;
    endtask

    task automatic readCheck(input logic [31:0] addr, input logic [31:0] mask,
                             input logic [31:0] expected, input logic [191:0] name);
        logic [31:0] actual;
        logic [31:0] outMask;
        logic [31:0] outActual;
        rdAddr = addr[4:0];
        #1;
        actual = rdData & mask;
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("FAILED %0s: expected %h, actual %h", name, expected, actual);
        end
        outMask   = outputFields(addr[4:0]) & mask;
        outActual = outputWord(addr[4:0]) & outMask;
        if (outMask != '0) begin
            checks++;
            assert (outActual == (expected & outMask)) else begin
                errors++;
                $display("FAILED %0s port: expected %h, actual %h", name,
                         expected & outMask, outActual);
            end
        end
    endtask

    task automatic raiseException(input logic [31:0] flags, input logic [31:0] pc,
                                  input logic [31:0] badAddr, input logic [31:0] delaySlot);
        excFlags       = flags[9:0];
        excPc          = pc;
        excBadAddr     = badAddr;
        excInDelaySlot = delaySlot[0];
        @(posedge clk);
        @(negedge clk);
        excFlags       = '0;
    endtask

    task automatic idleCycles(input logic [31:0] n);
        int i;
        for (i = 0; i < int'(n) && i < MaxCycles; i++) begin
            @(posedge clk);
            @(negedge clk);
        end
    endtask

    function automatic bit operandsOk(input int got, input int want, input int index);
        assert (got == want) else begin
            errors++;
            $display("Command %0d has %0d operands where %0d are needed", index, got, want);
        end
        return got == want;
    endfunction

    initial begin : replay
        int            fd;
        int            code;
        int            cmdCount;
        logic          done;
        logic [127:0]  cmdTok;
        logic [191:0]  name;
        logic [1023:0] rest;
        logic [31:0]   opA;
        logic [31:0]   opB;
        logic [31:0]   opC;
        logic [31:0]   opD;

        reset          = 1'b1;
        wrEn           = 1'b0;
        wrAddr         = '0;
        wrData         = '0;
        rdAddr         = '0;
        hwInt          = '0;
        excFlags       = '0;
        excPc          = '0;
        excBadAddr     = '0;
        excInDelaySlot = 1'b0;
        cmdCount       = 0;
        done           = 1'b0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        fd = $fopen(StimFile, "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open stimulus file %0s", StimFile);
        end else begin
            while (!done && cmdCount < MaxCommands) begin
                code = $fscanf(fd, "%s", cmdTok);
                if (code != 1) begin
                    done = 1'b1;
                end else begin
                    cmdCount++;
                    if (cmdTok == "#") begin
                        code = $fgets(rest, fd);   // Rest of a comment line
                    end else if (cmdTok == "W") begin
                        code = $fscanf(fd, "%h %h", opA, opB);
                        if (operandsOk(code, 2, cmdCount)) writeReg(opA, opB);
                    end else if (cmdTok == "R") begin
                        code = $fscanf(fd, "%h %h %h %s", opA, opB, opC, name);
                        if (operandsOk(code, 4, cmdCount)) readCheck(opA, opB, opC, name);
                    end else if (cmdTok == "E") begin
                        code = $fscanf(fd, "%h %h %h %h", opA, opB, opC, opD);
                        if (operandsOk(code, 4, cmdCount)) raiseException(opA, opB, opC, opD);
                    end else if (cmdTok == "H") begin
                        code = $fscanf(fd, "%h", opA);
                        if (operandsOk(code, 1, cmdCount)) hwInt = opA[5:0];
                    end else if (cmdTok == "I") begin
                        code = $fscanf(fd, "%h", opA);
                        if (operandsOk(code, 1, cmdCount)) idleCycles(opA);
                    end else begin
                        errors++;
                        $display("Unknown command %0s at command %0d", cmdTok, cmdCount);
                    end
                end
            end
            if (!done) begin
                errors++;
                $display("Stimulus file did not end within %0d commands", MaxCommands);
            end
            $fclose(fd);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/cp0Stim.txt
# Command then hex operands, one command per line
# W addr data | R addr mask expected name | E flags pc badAddr delaySlot | H hwInt | I cycles
# Park Compare away from Count so TI stays clear
W 0b ffffffff
W 0c 0000a501
R 0c ffffffff 0040a501 statusWrite
W 0c 0000ff02
R 0c ffffffff 0040ff02 statusExl
W 0e 12345678
R 0e ffffffff 12345678 epcWrite
W 0d 00000300
R 0d ffffffff 00000300 causeSoftIp
W 0d 00000000
W 08 deadbeef
R 08 ffffffff 00000000 badVAddrReadOnly
R 1f ffffffff 00000000 unmappedAddr
# Count advances every second edge
W 09 00000100
R 09 ffffffff 00000100 countK0
I 1
R 09 ffffffff 00000100 countK1
I 1
R 09 ffffffff 00000101 countK2
I 3
R 09 ffffffff 00000102 countK5
# Timer match at Compare 200
W 0b 00000200
W 09 000001fe
I 3
R 0d 40008000 00000000 timerBeforeMatch
I 2
R 0d 40008000 40008000 timerMatch
I 4
R 0d 40008000 40000000 timerSticky
W 0b ffffffff
R 0d 40000000 00000000 timerClear
# Exception entry and priority
W 0c 0000ff01
E 388 00400020 10000001 1
R 0d 8000007c 80000020 syscallPriority
R 0e ffffffff 0040001c epcDelaySlot
R 0c 00000003 00000003 exlSet
R 08 ffffffff 00000000 badVAddrKept
E 020 00000000 00000000 0
R 0c 00000002 00000000 eretClearsExl
E 300 00400100 20000003 0
R 0d 8000007c 00000014 storeOverLoad
R 0e ffffffff 00400100 epcNoSlot
R 08 ffffffff 20000003 badVAddrStore
E 020 00000000 00000000 0
E 006 00400206 30000000 0
R 0d 8000007c 00000010 fetchOverRi
R 08 ffffffff 00400206 badVAddrFetch
# Nested exception while EXL is set, then Eret
E 080 00400300 00000000 1
R 0d 8000007c 00000030 nestedCode
R 0e ffffffff 00400206 nestedEpcKept
E 020 00000000 00000000 0
R 0c 00000002 00000000 eretAfterNest
R 0e ffffffff 00400206 eretEpcKept
E 211 00400400 00000000 0
R 0d 0000007c 00000000 interruptCode
# Hardware lines show up one edge later
H 2a
R 0d 0000fc00 00000000 hwIntDelay
I 1
R 0d 0000fc00 0000a800 hwIntPattern
H 15
I 1
R 0d 0000fc00 00005400 hwIntChange
H 00

//--- files.f
source/cp0Pkg.sv
source/excPkg.sv
source/excPriority.sv
source/cp0Timer.sv
source/cp0Exception.sv
source/cp0Regs.sv
tests/cp0RegsTb.sv

//--- run.sh
#!/bin/sh
# Build the CP0 testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal --top-module cp0RegsTb \
    --Mdir "$OBJ" -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vcp0RegsTb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^=== PASS ===$" "$LOG"; then
    echo "Result: passed"
    exit 0
fi

echo "Result: failed"
exit 1
